// ==== sim.f ====
rtl/dl1_pkg.sv
rtl/dual_port_sram.sv
rtl/line_flag_array.sv
rtl/dl1_way.sv
rtl/victim_select.sv
rtl/dl1_controller.sv
rtl/dl1_cache.sv
test/dl1_cache_sva.sv
test/tb_dl1_cache.sv

// ==== Bender.yml ====
package:
  name: dl1_cache

sources:
  - rtl/dl1_pkg.sv
  - rtl/dual_port_sram.sv
  - rtl/line_flag_array.sv
  - rtl/dl1_way.sv
  - rtl/victim_select.sv
  - rtl/dl1_controller.sv
  - rtl/dl1_cache.sv
  - target: simulation
    files:
      - test/dl1_cache_sva.sv
      - test/tb_dl1_cache.sv

// ==== test/tb_dl1_cache.sv ====
// ============================================================
// Memory model covers line addresses 0..63 only, and all CPU
// traffic stays inside that range
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module tb_dl1_cache
	import dl1_pkg::*;
();

	localparam logic [31:0] SEED        = 32'h8059_adbc;
	localparam int          N_OPS       = 400;
	localparam int          MISS_CYCLES = 40;
	// Conflict ops, their back-to-back follow-ups and the read-back pass
	localparam int          LIMIT_NS    = (2 * N_OPS + 300) * MISS_CYCLES * 10;

	logic                   cache_clk;
	logic                   rst_n;
	logic                   cpu_read;
	logic                   cpu_write;
	logic [DATA_W-1:0]      cpu_addr;
	logic [DATA_W-1:0]      write_data;
	logic [DATA_W-1:0]      read_data;
	logic                   halt;
	logic                   dirty_req;
	logic [LINE_ADDR_W-1:0] dirty_addr;
	logic [LINE_W-1:0]      dirty_line;
	logic                   dirty_ack;
	logic                   fill_req;
	logic [LINE_ADDR_W-1:0] fill_addr;
	logic                   fill_valid;
	logic [DATA_W-1:0]      fill_data;

	// Backing store and CPU-visible reference per word
	logic [DATA_W-1:0] mem     [256];
	logic [DATA_W-1:0] ref_mem [256];
	logic [255:0]      written;
	logic [63:0]       touched;
	int                mismatch_count;
	int                other_count;
	logic [31:0]       stim_rng;
	logic [31:0]       gap_rng;

	dl1_cache DUT (.*);

	always #5 cache_clk = ~cache_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic note_mismatch(input string name, input logic [LINE_W-1:0] got,
		input logic [LINE_W-1:0] expected);
		mismatch_count++;
		$display("Mismatch %s: got %0h expected %0h", name, got, expected);
	endtask

	task automatic note_failure(input string what);
		other_count++;
		$display("Error: %s", what);
	endtask

	// Random wait of 0 to 3 cycles
	task automatic idle_gap();
		int gap;
		gap_rng = xorshift(gap_rng);
		gap = int'(gap_rng[1:0]);
		repeat (gap)
		begin
			@(posedge cache_clk);
			#1;
		end
	endtask

	//============================================================
	// Next-level memory
	//============================================================
	task automatic serve_evict();
		logic [LINE_W-1:0] expected;
		logic [5:0]        line;
		idle_gap();
		assert (dirty_req && !fill_req)
		else note_failure("write-back request dropped or refill started before the ack");
		assert (dirty_addr < 64) else note_failure("dirty_addr outside the memory model");
		line = dirty_addr[5:0];
		for (int w = 0; w < WORDS_PER_LINE; w++)
			expected[w*DATA_W +: DATA_W] = ref_mem[{line, w[1:0]}];
		assert (dirty_line == expected) else note_mismatch("dirty_line", dirty_line, expected);
		for (int w = 0; w < WORDS_PER_LINE; w++)
			mem[{line, w[1:0]}] = dirty_line[w*DATA_W +: DATA_W];
		dirty_ack = 1'b1;
		@(posedge cache_clk);
		#1;
		dirty_ack = 1'b0;
	endtask

	task automatic serve_fill();
		logic [LINE_ADDR_W-1:0] addr;
		addr = fill_addr;
		// Refill must fetch the line the CPU is waiting on
		assert (addr == {22'b0, cpu_addr[9:4]})
		else note_mismatch("fill_addr", addr, {22'b0, cpu_addr[9:4]});
		for (int w = 0; w < WORDS_PER_LINE; w++)
		begin
			idle_gap();
			assert (fill_req) else note_failure("refill request dropped before the last word");
			assert (fill_addr == addr) else note_mismatch("fill_addr", fill_addr, addr);
			fill_valid = 1'b1;
			fill_data  = mem[{addr[5:0], w[1:0]}];
			@(posedge cache_clk);
			#1;
			fill_valid = 1'b0;
		end
	endtask

	initial
	begin : memory_model
		dirty_ack  = 1'b0;
		fill_valid = 1'b0;
		fill_data  = '0;
		gap_rng    = ~SEED;
		@(posedge rst_n);
		forever
		begin
			@(posedge cache_clk);
			#1;
			if (dirty_req)
				serve_evict();
			else if (fill_req)
				serve_fill();
		end
	end

	//============================================================
	// CPU side
	//============================================================
	task automatic cpu_access(input logic is_write, input logic [7:0] word_addr,
		input logic [DATA_W-1:0] data, input logic expect_hit);
		cpu_read   = !is_write;
		cpu_write  = is_write;
		cpu_addr   = {22'b0, word_addr, 2'b00};
		write_data = data;
		@(negedge cache_clk);
		// Request cycle
		if (!touched[word_addr[7:2]])
			assert (halt) else note_failure("first access to a line did not miss");
		if (expect_hit)
			assert (!halt) else note_failure("access right after one to the same line missed");
		while (halt)
			@(negedge cache_clk);
		if (is_write)
		begin
			ref_mem[word_addr] = data;
			written[word_addr] = 1'b1;
		end
		else
			assert (read_data == ref_mem[word_addr])
			else note_mismatch("read_data", read_data, ref_mem[word_addr]);
		touched[word_addr[7:2]] = 1'b1;
		@(posedge cache_clk);
		#1;
		cpu_read  = 1'b0;
		cpu_write = 1'b0;
	endtask

	initial
	begin : stimulus
		logic [7:0] word_addr;
		int         sva_count;
		cache_clk      = 1'b0;
		rst_n          = 1'b0;
		cpu_read       = 1'b0;
		cpu_write      = 1'b0;
		cpu_addr       = '0;
		write_data     = '0;
		mismatch_count = 0;
		other_count    = 0;
		written        = '0;
		touched        = '0;
		stim_rng       = SEED;
		for (int i = 0; i < 256; i++)
		begin
			stim_rng   = xorshift(stim_rng);
			mem[i]     = stim_rng;
			ref_mem[i] = stim_rng;
		end
		repeat (2) @(posedge cache_clk);
		#1;
		rst_n = 1'b1;
		@(negedge cache_clk);
		assert (!halt && !dirty_req && !fill_req)
		else note_failure("halt or a request is high after reset");
		@(posedge cache_clk);
		#1;
		// Conflict traffic with 4 tags per set against 2 ways
		for (int i = 0; i < N_OPS; i++)
		begin
			stim_rng  = xorshift(stim_rng);
			word_addr = stim_rng[7:0];
			cpu_access(stim_rng[8], word_addr, {stim_rng[15:0], stim_rng[31:16]}, 1'b0);
			if (stim_rng[9])
				cpu_access(stim_rng[10], {word_addr[7:2], stim_rng[12:11]}, ~stim_rng, 1'b1);
		end
		// Read back every written word while evicting
		for (int a = 0; a < 256; a++)
		begin
			if (written[a])
				cpu_access(1'b0, 8'(a), '0, 1'b0);
		end
		sva_count = DUT.u_sva.assert_fail_count;
		$display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatch_count, other_count, sva_count);
		if (mismatch_count == 0 && other_count == 0 && sva_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin : watchdog
		#(LIMIT_NS);
		$display("Timeout: access sequence not finished after %0d ns", LIMIT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/dl1_cache_sva.sv ====
// ============================================================
// Port-level protocol checks sampled on the rising edge
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module dl1_cache_sva
	import dl1_pkg::*;
(
	input logic                   cache_clk,
	input logic                   rst_n,
	input logic                   cpu_read,
	input logic                   cpu_write,
	input logic [DATA_W-1:0]      cpu_addr,
	input logic                   halt,
	input logic                   dirty_req,
	input logic [LINE_ADDR_W-1:0] dirty_addr,
	input logic [LINE_W-1:0]      dirty_line,
	input logic                   dirty_ack,
	input logic                   fill_req
);

	ctrl_state_t phase;
	logic        req;
	int          assert_fail_count = 0;

	assign req = cpu_read || cpu_write;

	// Miss phase as seen from the request outputs
	always_comb
	begin
		if (dirty_req)
			phase = CTRL_EVICT;
		else if (fill_req)
			phase = CTRL_REFILL;
		else
			phase = CTRL_IDLE;
	end

	reset_quiet: assert property (@(posedge cache_clk)
		!rst_n |-> !dirty_req && !fill_req && !halt)
	else
	begin
		assert_fail_count++;
		$error("Request or halt active during reset");
	end

	one_request: assert property (@(posedge cache_clk) disable iff (!rst_n)
		!(dirty_req && fill_req))
	else
	begin
		assert_fail_count++;
		$error("Write-back and refill requests high together");
	end

	// Victim address and data frozen until the ack
	evict_hold: assert property (@(posedge cache_clk) disable iff (!rst_n)
		phase == CTRL_EVICT && !dirty_ack |=> phase == CTRL_EVICT && !fill_req
		&& $stable(dirty_addr) && $stable(dirty_line))
	else
	begin
		assert_fail_count++;
		$error("Write-back request changed before its ack");
	end

	same_line_hit: assert property (@(posedge cache_clk) disable iff (!rst_n)
		req && !halt ##1 req |-> !halt || (cpu_addr[DATA_W-1:BYTE_OFF_W+WORD_SEL_W]
		!= $past(cpu_addr[DATA_W-1:BYTE_OFF_W+WORD_SEL_W])))
	else
	begin
		assert_fail_count++;
		$error("Access to the line just used did not hit");
	end

endmodule

bind dl1_cache dl1_cache_sva u_sva (.*);

`default_nettype wire

// ==== rtl/dl1_cache.sv ====
// ============================================================
// Word accesses only, byte offset bits of cpu_addr are ignored
// Request must be held until an edge with halt low
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module dl1_cache
	import dl1_pkg::*;
(
	// CPU
	input  logic                   cpu_read,
	input  logic                   cpu_write,
	input  logic [DATA_W-1:0]      cpu_addr,
	input  logic [DATA_W-1:0]      write_data,
	output logic [DATA_W-1:0]      read_data,
	output logic                   halt,
	// Write-back
	output logic                   dirty_req,
	output logic [LINE_ADDR_W-1:0] dirty_addr,
	output logic [LINE_W-1:0]      dirty_line,
	input  logic                   dirty_ack,
	// Refill
	output logic                   fill_req,
	output logic [LINE_ADDR_W-1:0] fill_addr,
	input  logic                   fill_valid,
	input  logic [DATA_W-1:0]      fill_data,
	// System
	input  logic                   cache_clk,
	input  logic                   rst_n
);

	logic [TAG_W-1:0]       tag;
	logic [INDEX_W-1:0]     index;
	logic [WORD_SEL_W-1:0]  word_sel;
	logic [LINE_ADDR_W-1:0] line_addr;

	logic [WAYS-1:0]   way_hit;
	logic [WAYS-1:0]   way_valid;
	logic [WAYS-1:0]   way_dirty;
	logic [WAYS-1:0]   way_fill;
	logic [WAYS-1:0]   victim_way;
	logic [WAYS-1:0]   held_victim;
	logic [LINE_W-1:0] way_line [WAYS];
	logic [TAG_W-1:0]  way_tag  [WAYS];
	logic [LINE_W-1:0] fill_line;
	logic [LINE_W-1:0] hit_line;
	logic [TAG_W-1:0]  victim_tag;
	logic              hit;
	logic              victim_dirty;

	//============================================================
	// Address split
	//============================================================
	assign word_sel  = cpu_addr[BYTE_OFF_W +: WORD_SEL_W];
	assign index     = cpu_addr[BYTE_OFF_W + WORD_SEL_W +: INDEX_W];
	assign tag       = cpu_addr[DATA_W-1 -: TAG_W];
	assign line_addr = cpu_addr[DATA_W-1 -: LINE_ADDR_W];

	for (genvar w = 0; w < WAYS; w++)
	begin : way_gen
		dl1_way u_way
		(
			.cache_clk    (cache_clk),
			.rst_n        (rst_n),
			.index        (index),
			.tag          (tag),
			.word_sel     (word_sel),
			.write_data   (write_data),
			.cpu_write    (cpu_write),
			.install      (way_fill[w]),
			.install_tag  (fill_addr[LINE_ADDR_W-1 -: TAG_W]),
			.install_line (fill_line),
			.hit          (way_hit[w]),
			.valid        (way_valid[w]),
			.dirty        (way_dirty[w]),
			.line         (way_line[w]),
			.stored_tag   (way_tag[w])
		);
	end

	assign hit = |way_hit;

	// Read mux, at most one way hits
	always_comb
	begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			if (way_hit[w])
				hit_line = way_line[w];
		end
	end

	assign read_data = hit_line[word_sel*DATA_W +: DATA_W];

	// Victim contents from the way latched at the miss
	always_comb
	begin
		dirty_line = '0;
		victim_tag = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			if (held_victim[w])
			begin
				dirty_line = way_line[w];
				victim_tag = way_tag[w];
			end
		end
	end

	assign dirty_addr   = {victim_tag, index};
	assign victim_dirty = |(victim_way & way_dirty);

	victim_select u_victim
	(
		.cache_clk  (cache_clk),
		.rst_n      (rst_n),
		.valid      (way_valid),
		.victim_way (victim_way)
	);

	dl1_controller u_ctrl
	(
		.cache_clk    (cache_clk),
		.rst_n        (rst_n),
		.cpu_read     (cpu_read),
		.cpu_write    (cpu_write),
		.hit          (hit),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.dirty_ack    (dirty_ack),
		.fill_valid   (fill_valid),
		.fill_data    (fill_data),
		.line_addr    (line_addr),
		.halt         (halt),
		.dirty_req    (dirty_req),
		.fill_req     (fill_req),
		.fill_addr    (fill_addr),
		.way_fill     (way_fill),
		.fill_line    (fill_line),
		.held_victim  (held_victim)
	);

endmodule

`default_nettype wire

// ==== rtl/dl1_controller.sv ====
// ============================================================
// One miss at a time; refill words must arrive in order 0..3
// and the victim is only written back when it is dirty
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module dl1_controller
	import dl1_pkg::*;
(
	input  logic                   cache_clk,
	input  logic                   rst_n,
	input  logic                   cpu_read,
	input  logic                   cpu_write,
	input  logic                   hit,
	input  logic [WAYS-1:0]        victim_way,
	input  logic                   victim_dirty,
	input  logic                   dirty_ack,
	input  logic                   fill_valid,
	input  logic [DATA_W-1:0]      fill_data,
	input  logic [LINE_ADDR_W-1:0] line_addr,
	output logic                   halt,
	output logic                   dirty_req,
	output logic                   fill_req,
	output logic [LINE_ADDR_W-1:0] fill_addr,
	output logic [WAYS-1:0]        way_fill,
	output logic [LINE_W-1:0]      fill_line,
	output logic [WAYS-1:0]        held_victim
);

	ctrl_state_t           state;
	logic [WORD_SEL_W-1:0] word_cnt;
	logic [LINE_W-1:0]     fill_buf;
	logic                  miss;
	logic                  last_word;

	assign miss      = (cpu_read || cpu_write) && !hit;
	assign last_word = fill_valid && (word_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1));

	// Halt covers the request cycle of a miss and the whole handling
	assign halt = (state != CTRL_IDLE) || miss;

	// Install strobe on the edge of the final refill beat
	assign way_fill = ((state == CTRL_REFILL) && last_word) ? held_victim : '0;

	//============================================================
	// Miss FSM and handshakes
	//============================================================
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= CTRL_IDLE;
			dirty_req   <= 1'b0;
			fill_req    <= 1'b0;
			fill_addr   <= '0;
			held_victim <= '0;
			word_cnt    <= '0;
		end
		else
		begin
			case (state)
				CTRL_IDLE:
				begin
					if (miss)
					begin
						held_victim <= victim_way;
						fill_addr   <= line_addr;
						word_cnt    <= '0;
						if (victim_dirty)
						begin
							dirty_req <= 1'b1;
							state     <= CTRL_EVICT;
						end
						else
						begin
							fill_req <= 1'b1;
							state    <= CTRL_REFILL;
						end
					end
				end
				CTRL_EVICT:
				begin
					// Hand over straight from write-back to refill
					if (dirty_ack)
					begin
						dirty_req <= 1'b0;
						fill_req  <= 1'b1;
						state     <= CTRL_REFILL;
					end
				end
				CTRL_REFILL:
				begin
					if (fill_valid)
						word_cnt <= word_cnt + 1'b1;
					if (last_word)
					begin
						fill_req <= 1'b0;
						state    <= CTRL_IDLE;
					end
				end
				default:
				begin
					dirty_req <= 1'b0;
					fill_req  <= 1'b0;
					state     <= CTRL_IDLE;
				end
			endcase
		end
	end

	// Refill collection buffer
	always_ff @(posedge cache_clk)
	begin
		if ((state == CTRL_REFILL) && fill_valid)
			fill_buf[word_cnt*DATA_W +: DATA_W] <= fill_data;
	end

	// Last beat goes straight into the install line
	always_comb
	begin
		fill_line = fill_buf;
		fill_line[word_cnt*DATA_W +: DATA_W] = fill_data;
	end

endmodule

`default_nettype wire

// ==== rtl/victim_select.sv ====
// ============================================================
// Empty ways are filled first, lowest index wins; otherwise a
// free-running LFSR picks the way
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module victim_select
	import dl1_pkg::*;
(
	input  logic            cache_clk,
	input  logic            rst_n,
	input  logic [WAYS-1:0] valid,
	output logic [WAYS-1:0] victim_way
);

	logic [15:0]              lfsr;
	logic                     feedback;
	logic [$clog2(WAYS)-1:0]  rand_way;

	// Taps 16, 14, 13, 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			lfsr <= 16'hace1;
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	assign rand_way = lfsr[$clog2(WAYS)-1:0];

	// Walk down so the lowest invalid way is the last to overwrite
	always_comb
	begin
		victim_way = '0;
		victim_way[rand_way] = 1'b1;
		for (int w = WAYS - 1; w >= 0; w--)
		begin
			if (!valid[w])
			begin
				victim_way    = '0;
				victim_way[w] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dl1_way.sv ====
// ============================================================
// One way of the cache; install and a write hit never target
// the same way in the same cycle
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module dl1_way
	import dl1_pkg::*;
(
	input  logic                  cache_clk,
	input  logic                  rst_n,
	input  logic [INDEX_W-1:0]    index,
	input  logic [TAG_W-1:0]      tag,
	input  logic [WORD_SEL_W-1:0] word_sel,
	input  logic [DATA_W-1:0]     write_data,
	input  logic                  cpu_write,
	input  logic                  install,
	input  logic [TAG_W-1:0]      install_tag,
	input  logic [LINE_W-1:0]     install_line,
	output logic                  hit,
	output logic                  valid,
	output logic                  dirty,
	output logic [LINE_W-1:0]     line,
	output logic [TAG_W-1:0]      stored_tag
);

	logic              write_hit;
	logic              line_wen;
	logic [LINE_W-1:0] merged_line;
	logic [LINE_W-1:0] line_wdata;

	assign hit       = valid && (stored_tag == tag);
	assign write_hit = cpu_write && hit;

	// Store word replaces one slot of the current line
	always_comb
	begin
		merged_line = line;
		merged_line[word_sel*DATA_W +: DATA_W] = write_data;
	end

	assign line_wen   = install || write_hit;
	assign line_wdata = install ? install_line : merged_line;

	//============================================================
	// Storage
	//============================================================
	dual_port_sram
	#(
		.WIDTH (TAG_W),
		.DEPTH (SETS)
	)
	u_tag_ram
	(
		.cache_clk (cache_clk),
		.wen       (install),
		.waddr     (index),
		.wdata     (install_tag),
		.raddr     (index),
		.rdata     (stored_tag)
	);

	dual_port_sram
	#(
		.WIDTH (LINE_W),
		.DEPTH (SETS)
	)
	u_line_ram
	(
		.cache_clk (cache_clk),
		.wen       (line_wen),
		.waddr     (index),
		.wdata     (line_wdata),
		.raddr     (index),
		.rdata     (line)
	);

	// Valid is never dropped once a set is filled
	line_flag_array #(.DEPTH(SETS)) u_valid
	(
		.cache_clk  (cache_clk),
		.rst_n      (rst_n),
		.index      (index),
		.set_flag   (install),
		.clear_flag (1'b0),
		.flag       (valid)
	);

	// Fresh line from memory is clean
	line_flag_array #(.DEPTH(SETS)) u_dirty
	(
		.cache_clk  (cache_clk),
		.rst_n      (rst_n),
		.index      (index),
		.set_flag   (write_hit),
		.clear_flag (install),
		.flag       (dirty)
	);

endmodule

`default_nettype wire

// ==== rtl/line_flag_array.sv ====
// ============================================================
// One flag per set, all cleared by reset; clear beats set
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module line_flag_array
#(
	parameter int DEPTH = 16
)
(
	input  logic                     cache_clk,
	input  logic                     rst_n,
	input  logic [$clog2(DEPTH)-1:0] index,
	input  logic                     set_flag,
	input  logic                     clear_flag,
	output logic                     flag
);

	logic [DEPTH-1:0] flags;

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			flags <= '0;
		else if (clear_flag)
			flags[index] <= 1'b0;
		else if (set_flag)
			flags[index] <= 1'b1;
	end

	assign flag = flags[index];

endmodule

`default_nettype wire

// ==== rtl/dual_port_sram.sv ====
// ============================================================
// Read port is combinational, write lands on the rising edge
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module dual_port_sram
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
)
(
	input  logic                     cache_clk,
	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  logic [WIDTH-1:0]         wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]         rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge cache_clk)
	begin
		if (wen)
			mem[waddr] <= wdata;
	end

	// Asynchronous read, same cycle as the address
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== rtl/dl1_pkg.sv ====
// ============================================================
// Geometry is fixed at 2 ways, 16 sets, 4-word lines of 32 bits
// Controller state encoding shared with the protocol checks
// ============================================================
`default_nettype none

package dl1_pkg;

	// CPU word and address split
	localparam int DATA_W         = 32;
	localparam int BYTE_OFF_W     = 2;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_SEL_W     = 2;
	localparam int LINE_W         = DATA_W * WORDS_PER_LINE;

	// Set organisation
	localparam int SETS    = 16;
	localparam int INDEX_W = 4;
	localparam int WAYS    = 2;

	// Tag is whatever is left above index, word select and byte offset
	localparam int TAG_W       = DATA_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;
	localparam int LINE_ADDR_W = TAG_W + INDEX_W;

	// Miss handling states
	typedef enum logic [1:0]
	{
		CTRL_IDLE   = 2'd0,
		CTRL_EVICT  = 2'd1,
		CTRL_REFILL = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire
